/* Makefile */
VERILATOR ?= verilator
TOP       ?= trap_tb
RTL_TOP   ?= trap_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= PASS: all tests

SRCS := $(shell grep -v '^+' $(FILELIST))
RTL  := $(filter hw/%,$(SRCS))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL)

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
hw/trap_pkg.sv
hw/trap_sequencer.sv
hw/csr_file.sv
hw/trap_top.sv
verification/trap_sva.sv
verification/trap_tb.sv

/* hw/csr_file.sv */
`timescale 1ns/1ps

module csr_file #(
    parameter logic [trap_pkg::XLEN-1:0] MTVEC_RESET = 32'h0000_0100
) (
    input  logic                       clk,
    input  logic                       rst_n,

    // trap sequencer write port
    input  trap_pkg::csr_wr_t          csr_wr_i,

    // csr instruction port
    input  logic                       csr_acc_valid_i,
    input  trap_pkg::csr_acc_t         csr_acc_i,
    output logic [trap_pkg::XLEN-1:0]  csr_rdata_o,

    // live values for the sequencer
    output logic [trap_pkg::XLEN-1:0]  mtvec_o,
    output logic [trap_pkg::XLEN-1:0]  mepc_o,
    output logic [trap_pkg::XLEN-1:0]  mstatus_o
);

    import trap_pkg::*;

    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] mstatus_q;

    logic            wr_en;
    logic [11:0]     wr_addr;
    logic [XLEN-1:0] wr_data;

    // trap write wins, access write dropped on collision
    always_comb begin
        if (csr_wr_i.we) begin
            wr_en   = 1'b1;
            wr_addr = csr_wr_i.addr;
            wr_data = csr_wr_i.data;
        end else begin
            wr_en   = csr_acc_valid_i && csr_acc_i.we;
            wr_addr = csr_acc_i.addr;
            wr_data = csr_acc_i.wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec_q   <= MTVEC_RESET;
            mepc_q    <= '0;
            mcause_q  <= '0;
            mstatus_q <= '0;
        end else if (wr_en) begin
            unique case (wr_addr)
                CSR_MTVEC:   mtvec_q   <= {wr_data[XLEN-1:2], 2'b00};  // mode bits stay 0
                CSR_MEPC:    mepc_q    <= {wr_data[XLEN-1:2], 2'b00};  // word aligned
                CSR_MCAUSE:  mcause_q  <= wr_data;
                CSR_MSTATUS: mstatus_q <= wr_data;
                default:     ;  // unimplemented, write ignored
            endcase
        end
    end

    // combinational read for csr instructions
    always_comb begin
        unique case (csr_acc_i.addr)
            CSR_MTVEC:   csr_rdata_o = mtvec_q;
            CSR_MEPC:    csr_rdata_o = mepc_q;
            CSR_MCAUSE:  csr_rdata_o = mcause_q;
            CSR_MSTATUS: csr_rdata_o = mstatus_q;
            default:     csr_rdata_o = '0;  // everything else reads zero
        endcase
    end

    assign mtvec_o   = mtvec_q;
    assign mepc_o    = mepc_q;
    assign mstatus_o = mstatus_q;

endmodule

/* hw/trap_pkg.sv */
package trap_pkg;

    localparam int XLEN = 32;  // data and address width

    // machine csr addresses
    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    // mstatus bit positions
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;

    // synchronous exception codes
    localparam logic [XLEN-1:0] CAUSE_ECALL  = 32'd11;
    localparam logic [XLEN-1:0] CAUSE_EBREAK = 32'd3;

    typedef enum logic [1:0] {
        SYS_ECALL  = 2'd0,
        SYS_EBREAK = 2'd1,
        SYS_MRET   = 2'd2
    } sys_kind_e;

    // system op request from execute, 67 bits
    typedef struct packed {
        sys_kind_e         kind;
        logic [XLEN-1:0]   pc;         // address of the system instruction
        logic              jump_flag;  // branch taken in the same slot
        logic [XLEN-1:0]   jump_addr;
    } sys_req_t;

    // trap-side csr write, 45 bits
    typedef struct packed {
        logic              we;
        logic [11:0]       addr;
        logic [XLEN-1:0]   data;
    } csr_wr_t;

    // csr instruction access, 45 bits
    typedef struct packed {
        logic              we;
        logic [11:0]       addr;
        logic [XLEN-1:0]   wdata;
    } csr_acc_t;

    // fetch redirect, 33 bits
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   target;
    } redirect_t;

endpackage

/* hw/trap_sequencer.sv */
`timescale 1ns/1ps

module trap_sequencer (
    input  logic                       clk,
    input  logic                       rst_n,

    // request from execute
    input  logic                       sys_valid_i,
    input  trap_pkg::sys_req_t         sys_req_i,
    input  logic                       atom_busy_i,  // atomic op in flight
    output logic                       sys_ready_o,

    // current csr values
    input  logic [trap_pkg::XLEN-1:0]  mtvec_i,
    input  logic [trap_pkg::XLEN-1:0]  mepc_i,
    input  logic [trap_pkg::XLEN-1:0]  mstatus_i,

    output trap_pkg::csr_wr_t          csr_wr_o,
    output trap_pkg::redirect_t        redirect_o,
    output logic                       hold_o
);

    import trap_pkg::*;

    // one-hot sequence states
    typedef enum logic [4:0] {
        ST_IDLE   = 5'b00001,
        ST_MEPC   = 5'b00010,  // trap saves the return pc
        ST_MSTAT  = 5'b00100,  // trap stacks MIE into MPIE
        ST_MCAUSE = 5'b01000,  // trap cause then jump to mtvec
        ST_MRET   = 5'b10000   // mret restores MIE and jumps to mepc
    } state_e;

    state_e          state_q;
    state_e          state_d;
    logic            accept;
    logic [XLEN-1:0] ret_addr_q;  // captured mepc value
    logic [XLEN-1:0] cause_q;     // captured mcause value

    assign hold_o      = (state_q != ST_IDLE);  // stall for whole sequence
    assign sys_ready_o = (state_q == ST_IDLE) && !atom_busy_i;
    assign accept      = sys_valid_i && sys_ready_o;

    // next state
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    if (sys_req_i.kind == SYS_MRET) begin
                        state_d = ST_MRET;
                    end else begin
                        state_d = ST_MEPC;
                    end
                end
            end
            ST_MEPC:   state_d = ST_MSTAT;
            ST_MSTAT:  state_d = ST_MCAUSE;
            ST_MCAUSE: state_d = ST_IDLE;   // last held cycle
            ST_MRET:   state_d = ST_IDLE;
            default:   state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // return address and cause latched only on a trap
    always_ff @(posedge clk) begin
        if (accept && sys_req_i.kind != SYS_MRET) begin
            if (sys_req_i.jump_flag) begin
                ret_addr_q <= sys_req_i.jump_addr - XLEN'(4);  // branch target slot
            end else begin
                ret_addr_q <= sys_req_i.pc;
            end
            cause_q <= (sys_req_i.kind == SYS_EBREAK) ? CAUSE_EBREAK : CAUSE_ECALL;
        end
    end

    // one csr write per sequence state
    always_comb begin
        csr_wr_o          = '0;
        redirect_o        = '0;
        unique case (state_q)
            ST_MEPC: begin
                csr_wr_o.we   = 1'b1;
                csr_wr_o.addr = CSR_MEPC;
                csr_wr_o.data = ret_addr_q;
            end
            ST_MSTAT: begin
                csr_wr_o.we   = 1'b1;
                csr_wr_o.addr = CSR_MSTATUS;
                csr_wr_o.data = mstatus_i;
                csr_wr_o.data[MSTATUS_MPIE] = mstatus_i[MSTATUS_MIE];  // stack
                csr_wr_o.data[MSTATUS_MIE]  = 1'b0;                    // mask
            end
            ST_MCAUSE: begin
                csr_wr_o.we       = 1'b1;
                csr_wr_o.addr     = CSR_MCAUSE;
                csr_wr_o.data     = cause_q;
                redirect_o.valid  = 1'b1;
                redirect_o.target = mtvec_i;  // direct mode only
            end
            ST_MRET: begin
                csr_wr_o.we   = 1'b1;
                csr_wr_o.addr = CSR_MSTATUS;
                csr_wr_o.data = mstatus_i;
                csr_wr_o.data[MSTATUS_MIE]  = mstatus_i[MSTATUS_MPIE];  // unstack
                csr_wr_o.data[MSTATUS_MPIE] = 1'b1;
                redirect_o.valid  = 1'b1;
                redirect_o.target = mepc_i;
            end
            default: ;  // idle writes nothing
        endcase
    end

endmodule

/* hw/trap_top.sv */
`timescale 1ns/1ps

module trap_top #(
    parameter logic [trap_pkg::XLEN-1:0] MTVEC_RESET = 32'h0000_0100
) (
    input  logic                       clk,
    input  logic                       rst_n,

    // system op handshake
    input  logic                       sys_valid_i,
    input  trap_pkg::sys_req_t         sys_req_i,
    input  logic                       atom_busy_i,
    output logic                       sys_ready_o,

    // csr instruction access
    input  logic                       csr_acc_valid_i,
    input  trap_pkg::csr_acc_t         csr_acc_i,
    output logic [trap_pkg::XLEN-1:0]  csr_rdata_o,

    // to pipeline control and fetch
    output logic                       hold_o,
    output trap_pkg::redirect_t        redirect_o,
    output logic                       mie_o
);

    import trap_pkg::*;

    csr_wr_t         csr_wr;   // sequencer -> csr file
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mstatus;

    trap_sequencer u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .sys_valid_i (sys_valid_i),
        .sys_req_i   (sys_req_i),
        .atom_busy_i (atom_busy_i),
        .sys_ready_o (sys_ready_o),
        .mtvec_i     (mtvec),
        .mepc_i      (mepc),
        .mstatus_i   (mstatus),
        .csr_wr_o    (csr_wr),
        .redirect_o  (redirect_o),
        .hold_o      (hold_o)
    );

    csr_file #(
        .MTVEC_RESET (MTVEC_RESET)
    ) u_csr (
        .clk             (clk),
        .rst_n           (rst_n),
        .csr_wr_i        (csr_wr),
        .csr_acc_valid_i (csr_acc_valid_i),
        .csr_acc_i       (csr_acc_i),
        .csr_rdata_o     (csr_rdata_o),
        .mtvec_o         (mtvec),
        .mepc_o          (mepc),
        .mstatus_o       (mstatus)
    );

    assign mie_o = mstatus[MSTATUS_MIE];  // global interrupt enable

endmodule

/* verification/trap_sva.sv */
`timescale 1ns/1ps

module trap_sva (
    input logic                clk,
    input logic                rst_n,
    input logic                sys_valid_i,
    input trap_pkg::sys_req_t  sys_req_i,
    input logic                sys_ready_o,
    input logic                hold_o,
    input trap_pkg::redirect_t redirect_o
);

    import trap_pkg::*;

    logic accept;
    assign accept = sys_valid_i && sys_ready_o;  // handshake edge

    // waiting request stays put
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        sys_valid_i && !sys_ready_o |=> sys_valid_i && $stable(sys_req_i))
        else $error("request changed while waiting for ready");

    a_hold_ready: assert property (@(posedge clk) disable iff (!rst_n)
        !(hold_o && sys_ready_o))
        else $error("hold and ready high together");

    // trap redirect lands on T+3, not earlier
    a_trap_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        accept && sys_req_i.kind != SYS_MRET
        |=> !redirect_o.valid ##1 !redirect_o.valid ##1 redirect_o.valid)
        else $error("trap redirect not three cycles after accept");

    a_mret_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        accept && sys_req_i.kind == SYS_MRET |=> redirect_o.valid)
        else $error("mret redirect not one cycle after accept");

endmodule

bind trap_sequencer trap_sva u_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .sys_valid_i (sys_valid_i),
    .sys_req_i   (sys_req_i),
    .sys_ready_o (sys_ready_o),
    .hold_o      (hold_o),
    .redirect_o  (redirect_o)
);

/* verification/trap_tb.sv */
`timescale 1ns/1ps

module trap_tb;

    import trap_pkg::*;

    localparam logic [XLEN-1:0] MTVEC_INIT = 32'h0000_0180;  // non-default reset value for mtvec
    localparam int NUM_TESTS   = 5;
    localparam int TEST_CYCLES = 80;  // per-test budget for the watchdog

    logic            clk;
    logic            rst_n;
    logic            sys_valid_i;
    sys_req_t        sys_req_i;
    logic            atom_busy_i;
    logic            sys_ready_o;
    logic            csr_acc_valid_i;
    csr_acc_t        csr_acc_i;
    logic [XLEN-1:0] csr_rdata_o;
    logic            hold_o;
    redirect_t       redirect_o;
    logic            mie_o;

    int              err_count   = 0;
    logic [31:0]     lcg_state   = 32'h96781297;
    logic [XLEN-1:0] mtvec_model = MTVEC_INIT;  // expected mtvec

    trap_top #(.MTVEC_RESET(MTVEC_INIT)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    // watchdog sized from the test count
    initial begin
        #((16 + NUM_TESTS * TEST_CYCLES) * 8);
        $display("run timed out, DUT never finished the sequence");
        $display("FAIL: see errors above");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic sys_req_t make_req(input sys_kind_e kind, input logic [XLEN-1:0] pc,
                                          input logic jf, input logic [XLEN-1:0] ja);
        sys_req_t r;
        r.kind      = kind;
        r.pc        = pc;
        r.jump_flag = jf;
        r.jump_addr = ja;
        return r;
    endfunction

    task automatic check_redirect(input redirect_t got, input redirect_t exp, input string what);
        if (got !== exp) begin
            err_count++;
            $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_csr(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                             input string what);
        if (got !== exp) begin
            err_count++;
            $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            err_count++;
            $display("FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;  // drive point
    endtask

    task automatic write_csr(input logic [11:0] addr, input logic [XLEN-1:0] data);
        csr_acc_i.we    = 1'b1;
        csr_acc_i.addr  = addr;
        csr_acc_i.wdata = data;
        csr_acc_valid_i = 1'b1;
        step();  // lands on this edge
        csr_acc_valid_i = 1'b0;
        csr_acc_i.we    = 1'b0;
    endtask

    task automatic expect_csr(input logic [11:0] addr, input logic [XLEN-1:0] exp);
        csr_acc_i.we    = 1'b0;
        csr_acc_i.addr  = addr;
        csr_acc_valid_i = 1'b1;
        #1;  // read mux settles
        check_csr(csr_rdata_o, exp, $sformatf("csr %h read", addr));
        step();
        csr_acc_valid_i = 1'b0;
    endtask

    // hold valid until ready and return in cycle T+1
    task automatic send_req(input sys_req_t req);
        sys_req_i   = req;
        sys_valid_i = 1'b1;
        #1;
        while (!sys_ready_o) begin
            @(posedge clk);
            #2;
        end
        step();
        sys_valid_i = 1'b0;
    endtask

    // n held cycles with the redirect only in the last one
    task automatic run_sequence(input int n, input logic [XLEN-1:0] target);
        redirect_t exp;
        for (int i = 1; i <= n; i++) begin
            #1;
            exp = '0;
            if (i == n) begin
                exp.valid  = 1'b1;
                exp.target = target;
            end
            check_redirect(redirect_o, exp, $sformatf("redirect in held cycle %0d", i));
            check_bit(hold_o, 1'b1, "hold inside sequence");
            check_bit(sys_ready_o, 1'b0, "ready inside sequence");
            step();
        end
        check_bit(hold_o, 1'b0, "hold after sequence");  // exactly n cycles
        check_redirect(redirect_o, '0, "redirect after sequence");
    endtask

    task automatic test_access_port();
        logic [XLEN-1:0] v;
        expect_csr(CSR_MTVEC, MTVEC_INIT);  // reset values first
        expect_csr(CSR_MEPC, '0);
        expect_csr(CSR_MCAUSE, '0);
        expect_csr(CSR_MSTATUS, '0);
        v = next_rand();
        write_csr(CSR_MTVEC, v);
        mtvec_model = v & ~32'd3;  // direct mode drops the low bits
        expect_csr(CSR_MTVEC, mtvec_model);
        v = next_rand();
        write_csr(CSR_MEPC, v);
        expect_csr(CSR_MEPC, v & ~32'd3);
        v = next_rand();
        write_csr(CSR_MCAUSE, v);
        expect_csr(CSR_MCAUSE, v);
        v = next_rand();
        write_csr(CSR_MSTATUS, v);
        expect_csr(CSR_MSTATUS, v);
        write_csr(12'h7c0, next_rand());  // unimplemented custom csr
        expect_csr(12'h7c0, '0);
    endtask

    task automatic test_ecall();
        logic [XLEN-1:0] pc;
        pc          = next_rand() & ~32'd3;
        mtvec_model = next_rand() & ~32'd3;
        write_csr(CSR_MTVEC, mtvec_model);
        send_req(make_req(SYS_ECALL, pc, 1'b0, '0));
        run_sequence(3, mtvec_model);
        expect_csr(CSR_MEPC, pc);
        expect_csr(CSR_MCAUSE, 32'd11);  // environment call from M
    endtask

    task automatic test_ebreak_jump();
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] ja;
        pc = next_rand() & ~32'd3;
        ja = next_rand() & ~32'd3;
        send_req(make_req(SYS_EBREAK, pc, 1'b1, ja));
        run_sequence(3, mtvec_model);
        expect_csr(CSR_MEPC, ja - 32'd4);  // slot before the jump target
        expect_csr(CSR_MCAUSE, 32'd3);     // breakpoint
    endtask

    task automatic test_mstatus_round_trip();
        logic [XLEN-1:0] pc;
        pc = next_rand() & ~32'd3;
        write_csr(CSR_MSTATUS, 32'h0000_0008);  // MIE only
        check_bit(mie_o, 1'b1, "mie_o after set");
        send_req(make_req(SYS_ECALL, pc, 1'b0, '0));
        run_sequence(3, mtvec_model);
        expect_csr(CSR_MSTATUS, 32'h0000_0080);  // MPIE set and MIE cleared
        check_bit(mie_o, 1'b0, "mie_o inside handler");
        send_req(make_req(SYS_MRET, '0, 1'b0, '0));
        run_sequence(1, pc);  // back to mepc
        expect_csr(CSR_MSTATUS, 32'h0000_0088);
        check_bit(mie_o, 1'b1, "mie_o after mret");
        write_csr(CSR_MSTATUS, 32'h0000_0000);  // MPIE clear before the second mret
        send_req(make_req(SYS_MRET, '0, 1'b0, '0));
        run_sequence(1, pc);
        expect_csr(CSR_MSTATUS, 32'h0000_0080);  // MIE follows MPIE and MPIE forced high
        check_bit(mie_o, 1'b0, "mie_o after mret with MPIE clear");
    endtask

    task automatic test_back_pressure();
        logic [XLEN-1:0] pc;
        pc          = next_rand() & ~32'd3;
        atom_busy_i = 1'b1;
        sys_req_i   = make_req(SYS_ECALL, pc, 1'b0, '0);
        sys_valid_i = 1'b1;
        repeat (4) begin
            #1;
            check_bit(sys_ready_o, 1'b0, "ready while atomic busy");
            check_bit(hold_o, 1'b0, "hold while atomic busy");
            check_redirect(redirect_o, '0, "redirect while atomic busy");
            step();
        end
        atom_busy_i = 1'b0;
        send_req(make_req(SYS_ECALL, pc, 1'b0, '0));
        sys_req_i   = make_req(SYS_MRET, '0, 1'b0, '0);  // queued right behind
        sys_valid_i = 1'b1;
        run_sequence(3, mtvec_model);  // mret must not slip in here
        send_req(make_req(SYS_MRET, '0, 1'b0, '0));
        run_sequence(1, pc);
    endtask

    initial begin
        rst_n           = 1'b0;
        sys_valid_i     = 1'b0;
        sys_req_i       = '0;
        atom_busy_i     = 1'b0;
        csr_acc_valid_i = 1'b0;
        csr_acc_i       = '0;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
        test_access_port();
        test_ecall();
        test_ebreak_jump();
        test_mstatus_round_trip();
        test_back_pressure();
        $display("trap_tb done, %0d errors", err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
